// ==== Bender.yml ====
package:
  name: mempool_system

sources:
  - system_pkg.sv
  - credit_fifo.sv
  - sys_addr_decoder.sv
  - l2_memory.sv
  - ctrl_registers.sv
  - rsp_reorder.sv
  - mempool_system.sv
  - target: simulation
    files:
      - tb_mempool_system.sv

// ==== credit_fifo.sv ====
`default_nettype none

module credit_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     credit_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t                mem_q [Depth];
  logic     [PtrWidth-1:0] wr_ptr_q;
  logic     [PtrWidth-1:0] rd_ptr_q;
  logic     [CntWidth-1:0] count_q;
  logic                    credit_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntWidth'(push_i) - CntWidth'(pop_i);
      credit_q <= pop_i; // the freed slot goes back to the sender.
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o   = mem_q[rd_ptr_q];
  assign empty_o  = (count_q == '0);
  assign credit_o = credit_q;

endmodule : credit_fifo

`default_nettype wire

// ==== ctrl_registers.sv ====
`default_nettype none

module ctrl_registers #(
  parameter int unsigned       NumCores        = 4,
  parameter system_pkg::addr_t TcdmBaseAddr    = '0,
  parameter int unsigned       TcdmSizePerCore = 4096
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  system_pkg::sys_req_t req_i,
  output logic                 rsp_valid_o,
  output system_pkg::sys_rsp_t rsp_o,
  output logic [NumCores-1:0]  wake_up_o,
  output logic                 eoc_valid_o
);

  import system_pkg::*;

  localparam addr_t TcdmEndAddr = TcdmBaseAddr + addr_t'(NumCores * TcdmSizePerCore) - 1;

  logic                in_page;
  logic [7:0]          offset;
  logic                eoc_wr;
  logic                wake_wr;
  sys_rsp_t            rsp_d;
  sys_rsp_t            rsp_q;
  logic                rsp_valid_q;
  data_t               eoc_q;
  logic                eoc_valid_q;
  logic [NumCores-1:0] wake_up_q;

  assign in_page = (req_i.addr[15:8] == 8'h00);
  assign offset  = req_i.addr[7:0];
  assign eoc_wr  = valid_i && req_i.we && in_page && (offset == EocOffset);
  assign wake_wr = valid_i && req_i.we && in_page && (offset == WakeUpOffset);

  always_comb begin
    rsp_d = '0;
    if (!in_page) begin
      rsp_d.err = 1'b1;
    end else begin
      case (offset)
        EocOffset:       rsp_d.rdata = req_i.we ? '0 : eoc_q;
        WakeUpOffset:    rsp_d.rdata = '0;
        TcdmStartOffset: rsp_d.rdata = req_i.we ? '0 : TcdmBaseAddr;
        TcdmEndOffset:   rsp_d.rdata = req_i.we ? '0 : TcdmEndAddr;
        NumCoresOffset:  rsp_d.rdata = req_i.we ? '0 : data_t'(NumCores);
        default:         rsp_d.err   = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      eoc_q       <= '0;
      eoc_valid_q <= 1'b0;
      wake_up_q   <= '0;
    end else begin
      rsp_valid_q <= valid_i;
      wake_up_q   <= wake_wr ? req_i.wdata[NumCores-1:0] : '0; // one-cycle pulse.
      if (eoc_wr) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) begin
            eoc_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        eoc_valid_q <= req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_valid_q;

endmodule : ctrl_registers

`default_nettype wire

// ==== l2_memory.sv ====
`default_nettype none

module l2_memory #(
  parameter int unsigned L2AddrWidth = 10
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  system_pkg::sys_req_t req_i,
  output logic                 rsp_valid_o,
  output system_pkg::sys_rsp_t rsp_o
);

  import system_pkg::*;

  localparam int unsigned NumWords = 2 ** L2AddrWidth;

  data_t                   mem_q [NumWords];
  logic  [L2AddrWidth-1:0] word_idx;
  logic                    rsp_valid_q;
  sys_rsp_t                rsp_q;

  assign word_idx = req_i.addr[L2AddrWidth+1:2]; // upper window bits alias.

  always_ff @(posedge clk_i) begin
    if (valid_i && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.strb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q.rdata <= req_i.we ? '0 : mem_q[word_idx];
      rsp_q.err   <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule : l2_memory

`default_nettype wire

// ==== list.f ====
system_pkg.sv
credit_fifo.sv
sys_addr_decoder.sv
l2_memory.sv
ctrl_registers.sv
rsp_reorder.sv
mempool_system.sv
tb_mempool_system.sv

// ==== mempool_system.sv ====
`default_nettype none

module mempool_system #(
  parameter int unsigned       NumCores        = 4,
  parameter system_pkg::addr_t TcdmBaseAddr    = '0,
  parameter int unsigned       TcdmSizePerCore = 4096,
  parameter int unsigned       L2AddrWidth     = 10,
  parameter int unsigned       ReqCredits      = 4,
  parameter int unsigned       RspCredits      = 4,
  parameter int unsigned       OrderDepth      = 8
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  system_pkg::sys_req_t req_i,
  output logic                 req_credit_o,
  output logic                 rsp_valid_o,
  output system_pkg::sys_rsp_t rsp_o,
  input  logic                 rsp_credit_i,
  output logic                 ext_req_valid_o,
  output system_pkg::sys_req_t ext_req_o,
  input  logic                 ext_req_credit_i,
  input  logic                 ext_rsp_valid_i,
  input  system_pkg::sys_rsp_t ext_rsp_i,
  output logic                 ext_rsp_credit_o,
  output logic [NumCores-1:0]  wake_up_o,
  output logic                 eoc_valid_o,
  output logic                 busy_o
);

  import system_pkg::*;

  sys_req_t                  req_head;
  logic                      req_empty;
  logic                      req_pop;
  logic                      order_full;
  logic                      order_push;
  target_e                   order_target;
  logic                      l2_valid;
  logic                      ctrl_valid;
  sys_req_t                  tgt_req;
  logic                      l2_rsp_valid;
  sys_rsp_t                  l2_rsp;
  logic                      ctrl_rsp_valid;
  sys_rsp_t                  ctrl_rsp;
  logic     [NumTargets-1:0] rsp_empty;
  sys_rsp_t [NumTargets-1:0] rsp_head;
  logic     [NumTargets-1:0] rsp_pop;

  assign ext_req_o = tgt_req;

  credit_fifo #(.payload_t(sys_req_t), .Depth(ReqCredits)) u_req_fifo (
    .clk_i   (clk_i       ),
    .reset_i (reset_i     ),
    .push_i  (req_valid_i ),
    .data_i  (req_i       ),
    .pop_i   (req_pop     ),
    .data_o  (req_head    ),
    .empty_o (req_empty   ),
    .credit_o(req_credit_o)
  );

  sys_addr_decoder #(.ReqCredits(ReqCredits)) u_decoder (
    .clk_i         (clk_i           ),
    .reset_i       (reset_i         ),
    .req_empty_i   (req_empty       ),
    .req_i         (req_head        ),
    .req_pop_o     (req_pop         ),
    .order_full_i  (order_full      ),
    .order_push_o  (order_push      ),
    .order_target_o(order_target    ),
    .l2_valid_o    (l2_valid        ),
    .ctrl_valid_o  (ctrl_valid      ),
    .ext_valid_o   (ext_req_valid_o ),
    .tgt_req_o     (tgt_req         ),
    .ext_credit_i  (ext_req_credit_i)
  );

  l2_memory #(.L2AddrWidth(L2AddrWidth)) u_l2_memory (
    .clk_i      (clk_i       ),
    .reset_i    (reset_i     ),
    .valid_i    (l2_valid    ),
    .req_i      (tgt_req     ),
    .rsp_valid_o(l2_rsp_valid),
    .rsp_o      (l2_rsp      )
  );

  ctrl_registers #(
    .NumCores       (NumCores       ),
    .TcdmBaseAddr   (TcdmBaseAddr   ),
    .TcdmSizePerCore(TcdmSizePerCore)
  ) u_ctrl_registers (
    .clk_i      (clk_i         ),
    .reset_i    (reset_i       ),
    .valid_i    (ctrl_valid    ),
    .req_i      (tgt_req       ),
    .rsp_valid_o(ctrl_rsp_valid),
    .rsp_o      (ctrl_rsp      ),
    .wake_up_o  (wake_up_o     ),
    .eoc_valid_o(eoc_valid_o   )
  );

  // l2 and ctrl FIFOs match the order queue depth, so they never need credits.
  credit_fifo #(.payload_t(sys_rsp_t), .Depth(OrderDepth)) u_ctrl_rsp_fifo (
    .clk_i   (clk_i                   ),
    .reset_i (reset_i                 ),
    .push_i  (ctrl_rsp_valid          ),
    .data_i  (ctrl_rsp                ),
    .pop_i   (rsp_pop[CtrlRegisters]  ),
    .data_o  (rsp_head[CtrlRegisters] ),
    .empty_o (rsp_empty[CtrlRegisters]),
    .credit_o(                        )
  );

  credit_fifo #(.payload_t(sys_rsp_t), .Depth(OrderDepth)) u_l2_rsp_fifo (
    .clk_i   (clk_i              ),
    .reset_i (reset_i            ),
    .push_i  (l2_rsp_valid       ),
    .data_i  (l2_rsp             ),
    .pop_i   (rsp_pop[L2Memory]  ),
    .data_o  (rsp_head[L2Memory] ),
    .empty_o (rsp_empty[L2Memory]),
    .credit_o(                   )
  );

  credit_fifo #(.payload_t(sys_rsp_t), .Depth(RspCredits)) u_ext_rsp_fifo (
    .clk_i   (clk_i              ),
    .reset_i (reset_i            ),
    .push_i  (ext_rsp_valid_i    ),
    .data_i  (ext_rsp_i          ),
    .pop_i   (rsp_pop[External]  ),
    .data_o  (rsp_head[External] ),
    .empty_o (rsp_empty[External]),
    .credit_o(ext_rsp_credit_o   )
  );

  rsp_reorder #(.OrderDepth(OrderDepth), .RspCredits(RspCredits)) u_rsp_reorder (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .order_push_i  (order_push  ),
    .order_target_i(order_target),
    .order_full_o  (order_full  ),
    .empty_i       (rsp_empty   ),
    .rsp_i         (rsp_head    ),
    .pop_o         (rsp_pop     ),
    .rsp_valid_o   (rsp_valid_o ),
    .rsp_o         (rsp_o       ),
    .rsp_credit_i  (rsp_credit_i),
    .busy_o        (busy_o      )
  );

endmodule : mempool_system

`default_nettype wire

// ==== rsp_reorder.sv ====
`default_nettype none

module rsp_reorder #(
  parameter int unsigned OrderDepth = 8,
  parameter int unsigned RspCredits = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic                                                 order_push_i,
  input  system_pkg::target_e                                  order_target_i,
  output logic                                                 order_full_o,
  input  logic                 [system_pkg::NumTargets-1:0]    empty_i,
  input  system_pkg::sys_rsp_t [system_pkg::NumTargets-1:0]    rsp_i,
  output logic                 [system_pkg::NumTargets-1:0]    pop_o,
  output logic                                                 rsp_valid_o,
  output system_pkg::sys_rsp_t                                 rsp_o,
  input  logic                                                 rsp_credit_i,
  output logic                                                 busy_o
);

  import system_pkg::*;

  localparam int unsigned OrdWidth = $clog2(OrderDepth + 1);
  localparam int unsigned RspWidth = $clog2(RspCredits + 1);

  target_e             head;
  logic                order_empty;
  logic                order_credit;
  logic                emit;
  logic [OrdWidth-1:0] order_slots_q;
  logic [RspWidth-1:0] rsp_credits_q;
  logic                rsp_valid_q;
  sys_rsp_t            rsp_q;

  credit_fifo #(
    .payload_t(target_e  ),
    .Depth    (OrderDepth)
  ) u_order_fifo (
    .clk_i   (clk_i         ),
    .reset_i (reset_i       ),
    .push_i  (order_push_i  ),
    .data_i  (order_target_i),
    .pop_i   (emit          ),
    .data_o  (head          ),
    .empty_o (order_empty   ),
    .credit_o(order_credit  )
  );

  // the head target's response must be present and a response credit held.
  assign emit = !order_empty && !empty_i[head] && (rsp_credits_q != '0);

  always_comb begin
    pop_o = '0;
    if (emit) begin
      pop_o[head] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      order_slots_q <= OrdWidth'(OrderDepth);
      rsp_credits_q <= RspWidth'(RspCredits);
      rsp_valid_q   <= 1'b0;
    end else begin
      order_slots_q <= order_slots_q + OrdWidth'(order_credit) - OrdWidth'(order_push_i);
      rsp_credits_q <= rsp_credits_q + RspWidth'(rsp_credit_i) - RspWidth'(emit);
      rsp_valid_q   <= emit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit) begin
      rsp_q <= rsp_i[head];
    end
  end

  assign order_full_o = (order_slots_q == '0);
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_o        = rsp_q;
  assign busy_o       = !order_empty;

endmodule : rsp_reorder

`default_nettype wire

// ==== sys_addr_decoder.sv ====
`default_nettype none

module sys_addr_decoder #(
  parameter int unsigned ReqCredits = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_empty_i,
  input  system_pkg::sys_req_t req_i,
  output logic                 req_pop_o,
  input  logic                 order_full_i,
  output logic                 order_push_o,
  output system_pkg::target_e  order_target_o,
  output logic                 l2_valid_o,
  output logic                 ctrl_valid_o,
  output logic                 ext_valid_o,
  output system_pkg::sys_req_t tgt_req_o,
  input  logic                 ext_credit_i
);

  import system_pkg::*;

  localparam int unsigned CntWidth = $clog2(ReqCredits + 1);

  target_e             target;
  logic                tgt_ready;
  logic                pop;
  logic                pop_ext;
  logic [CntWidth-1:0] ext_credits_q;
  logic                l2_valid_q;
  logic                ctrl_valid_q;
  logic                ext_valid_q;
  sys_req_t            req_q;

  always_comb begin
    if (req_i.addr >= CtrlBaseAddr && req_i.addr <= CtrlEndAddr) begin
      target = CtrlRegisters;
    end else if (req_i.addr >= L2BaseAddr && req_i.addr <= L2EndAddr) begin
      target = L2Memory;
    end else begin
      target = External;
    end
  end

  // only the external port needs a credit because l2 and ctrl responses always find room.
  assign tgt_ready = (target != External) || (ext_credits_q != '0);
  assign pop       = !req_empty_i && !order_full_i && tgt_ready;
  assign pop_ext   = pop && (target == External);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ext_credits_q <= CntWidth'(ReqCredits);
      l2_valid_q    <= 1'b0;
      ctrl_valid_q  <= 1'b0;
      ext_valid_q   <= 1'b0;
    end else begin
      ext_credits_q <= ext_credits_q + CntWidth'(ext_credit_i) - CntWidth'(pop_ext);
      l2_valid_q    <= pop && (target == L2Memory);
      ctrl_valid_q  <= pop && (target == CtrlRegisters);
      ext_valid_q   <= pop_ext;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      req_q <= req_i;
    end
  end

  assign req_pop_o      = pop;
  assign order_push_o   = pop; // order is recorded at the same time the request leaves.
  assign order_target_o = target;
  assign l2_valid_o     = l2_valid_q;
  assign ctrl_valid_o   = ctrl_valid_q;
  assign ext_valid_o    = ext_valid_q;
  assign tgt_req_o      = req_q;

endmodule : sys_addr_decoder

`default_nettype wire

// ==== system_pkg.sv ====
`default_nettype none

package system_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  localparam int unsigned NumTargets = 3;

  // Each value doubles as the index of that target's response FIFO.
  typedef enum logic [1:0] {
    CtrlRegisters = 2'd0,
    L2Memory      = 2'd1,
    External      = 2'd2
  } target_e;

  // Reads and writes share one request word per transaction.
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } sys_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } sys_rsp_t;

  localparam addr_t CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlEndAddr  = 32'h4000_FFFF;
  localparam addr_t L2BaseAddr   = 32'h8000_0000;
  localparam addr_t L2EndAddr    = 32'hBFFF_FFFF;

  localparam logic [7:0] EocOffset       = 8'h00;
  localparam logic [7:0] WakeUpOffset    = 8'h04;
  localparam logic [7:0] TcdmStartOffset = 8'h08;
  localparam logic [7:0] TcdmEndOffset   = 8'h0C;
  localparam logic [7:0] NumCoresOffset  = 8'h10;

endpackage : system_pkg

`default_nettype wire

// ==== tb_mempool_system.sv ====
`default_nettype none

module tb_mempool_system;

  timeunit 1ns;
  timeprecision 1ps;

  import system_pkg::*;

  localparam int unsigned NumCores        = 4;
  localparam addr_t       TcdmBaseAddr    = 32'h0000_0000;
  localparam int unsigned TcdmSizePerCore = 4096;
  localparam int unsigned L2AddrWidth     = 10;
  localparam int unsigned ReqCredits      = 4;
  localparam int unsigned RspCredits      = 4;
  localparam int unsigned OrderDepth      = 8;

  localparam int    NumPhase1  = 26;
  localparam int    NumBp      = 16;
  localparam int    NumEntries = NumPhase1 + NumBp;
  localparam int    Timeout    = 500;
  localparam int    SideNone   = 0;
  localparam int    SideEoc    = 1;
  localparam int    SideWake   = 2;
  localparam data_t ExtPattern = 32'hA5A5_A5A5;

  logic                clk_i            = 1'b0;
  logic                reset_i          = 1'b1;
  logic                req_valid_i      = 1'b0;
  sys_req_t            req_i            = '0;
  logic                req_credit_o;
  logic                rsp_valid_o;
  sys_rsp_t            rsp_o;
  logic                rsp_credit_i     = 1'b0;
  logic                ext_req_valid_o;
  sys_req_t            ext_req_o;
  logic                ext_req_credit_i = 1'b0;
  logic                ext_rsp_valid_i  = 1'b0;
  sys_rsp_t            ext_rsp_i        = '0;
  logic                ext_rsp_credit_o;
  logic [NumCores-1:0] wake_up_o;
  logic                eoc_valid_o;
  logic                busy_o;

  string    tbl_name  [NumEntries];
  sys_req_t tbl_req   [NumEntries];
  data_t    tbl_rdata [NumEntries];
  logic     tbl_err   [NumEntries];
  int       tbl_side  [NumEntries];
  int       n_entries = 0;

  int                  send_limit   = 0;
  bit                  hold_credits = 1'b0;
  int                  rsp_count    = 0;
  int                  wake_pulses  = 0;
  logic [NumCores-1:0] wake_value   = '0;
  int                  tests_run    = 0;
  int                  tests_failed = 0;
  int                  error_count  = 0;
  int                  exp_q [$];
  sys_req_t            ext_exp_q [$];
  int                  req_credits;
  int                  next_idx;
  int                  owed;
  sys_req_t            ext_pend_q [$];
  int                  ext_ready_q [$];
  data_t               ext_mem [addr_t];
  int                  ext_rsp_credits;
  int                  ext_cycle;
  logic [31:0]         lcg_state;

  mempool_system #(
    .NumCores       (NumCores       ),
    .TcdmBaseAddr   (TcdmBaseAddr   ),
    .TcdmSizePerCore(TcdmSizePerCore),
    .L2AddrWidth    (L2AddrWidth    ),
    .ReqCredits     (ReqCredits     ),
    .RspCredits     (RspCredits     ),
    .OrderDepth     (OrderDepth     )
  ) u_mempool_system (
    .clk_i           (clk_i           ),
    .reset_i         (reset_i         ),
    .req_valid_i     (req_valid_i     ),
    .req_i           (req_i           ),
    .req_credit_o    (req_credit_o    ),
    .rsp_valid_o     (rsp_valid_o     ),
    .rsp_o           (rsp_o           ),
    .rsp_credit_i    (rsp_credit_i    ),
    .ext_req_valid_o (ext_req_valid_o ),
    .ext_req_o       (ext_req_o       ),
    .ext_req_credit_i(ext_req_credit_i),
    .ext_rsp_valid_i (ext_rsp_valid_i ),
    .ext_rsp_i       (ext_rsp_i       ),
    .ext_rsp_credit_o(ext_rsp_credit_o),
    .wake_up_o       (wake_up_o       ),
    .eoc_valid_o     (eoc_valid_o     ),
    .busy_o          (busy_o          )
  );

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit is_external(input addr_t addr);
    bit in_ctrl;
    bit in_l2;
    in_ctrl = (addr >= CtrlBaseAddr) && (addr <= CtrlEndAddr);
    in_l2   = (addr >= L2BaseAddr) && (addr <= L2EndAddr);
    return !in_ctrl && !in_l2;
  endfunction

  task automatic check_value(input string name, input logic [68:0] expected,
                             input logic [68:0] actual, inout bit ok);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      error_count++;
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    tests_run++;
    if (ok) begin
      $display("[PASS] %s", name);
    end else begin
      $display("[FAIL] %s", name);
      tests_failed++;
    end
  endtask

  task automatic add_entry(input string name, input logic we, input addr_t addr,
                           input data_t wdata, input strb_t strb, input data_t rdata,
                           input logic err, input int side);
    tbl_name[n_entries]       = name;
    tbl_req[n_entries].addr   = addr;
    tbl_req[n_entries].wdata  = wdata;
    tbl_req[n_entries].strb   = strb;
    tbl_req[n_entries].we     = we;
    tbl_rdata[n_entries]      = rdata;
    tbl_err[n_entries]        = err;
    tbl_side[n_entries]       = side;
    n_entries++;
  endtask

  task automatic build_table();
    data_t tcdm_end;
    addr_t bp_addr;
    tcdm_end = TcdmBaseAddr + data_t'(NumCores * TcdmSizePerCore) - 1;
    add_entry("l2_wr_full", 1'b1, 32'h8000_0000, 32'hDEAD_BEEF, 4'hF, '0, 1'b0, SideNone);
    add_entry("l2_wr_word1", 1'b1, 32'h8000_0004, 32'h1122_3344, 4'hF, '0, 1'b0, SideNone);
    add_entry("l2_wr_part_lo", 1'b1, 32'h8000_0000, 32'h0000_AA55, 4'h3, '0, 1'b0, SideNone);
    add_entry("l2_wr_part_hi", 1'b1, 32'h8000_0004, 32'h9900_0000, 4'h8, '0, 1'b0, SideNone);
    add_entry("l2_rd_merged0", 1'b0, 32'h8000_0000, '0, 4'hF, 32'hDEAD_AA55, 1'b0, SideNone);
    add_entry("l2_rd_merged1", 1'b0, 32'h8000_0004, '0, 4'hF, 32'h9922_3344, 1'b0, SideNone);
    add_entry("ctrl_rd_tcdm_start", 1'b0, 32'h4000_0008, '0, 4'hF, TcdmBaseAddr, 1'b0,
              SideNone);
    add_entry("ctrl_rd_tcdm_end", 1'b0, 32'h4000_000C, '0, 4'hF, tcdm_end, 1'b0, SideNone);
    add_entry("ctrl_rd_num_cores", 1'b0, 32'h4000_0010, '0, 4'hF, NumCores, 1'b0, SideNone);
    add_entry("ctrl_wr_read_only", 1'b1, 32'h4000_0010, 32'hFFFF_FFFF, 4'hF, '0, 1'b0,
              SideNone);
    add_entry("ctrl_rd_read_only", 1'b0, 32'h4000_0010, '0, 4'hF, NumCores, 1'b0, SideNone);
    add_entry("ctrl_wr_eoc", 1'b1, 32'h4000_0000, 32'h0000_0001, 4'hF, '0, 1'b0, SideEoc);
    add_entry("ctrl_rd_eoc", 1'b0, 32'h4000_0000, '0, 4'hF, 32'h0000_0001, 1'b0, SideNone);
    add_entry("ctrl_wr_wake_up", 1'b1, 32'h4000_0004, 32'h0000_00FA, 4'hF, '0, 1'b0,
              SideWake);
    add_entry("ctrl_bad_offset", 1'b0, 32'h4000_0020, '0, 4'hF, '0, 1'b1, SideNone);
    add_entry("ext_wr", 1'b1, 32'h1000_0010, 32'hCAFE_F00D, 4'hF, '0, 1'b0, SideNone);
    add_entry("ext_rd_written", 1'b0, 32'h1000_0010, '0, 4'hF, 32'hCAFE_F00D, 1'b0, SideNone);
    add_entry("ext_rd_unwritten", 1'b0, 32'h2000_0100, '0, 4'hF,
              32'h2000_0100 ^ ExtPattern, 1'b0, SideNone);
    // the interleaved burst mixes all three targets, its external addresses border the windows.
    add_entry("mix_l2_wr", 1'b1, 32'h8000_0100, 32'h0BAD_CAFE, 4'hF, '0, 1'b0, SideNone);
    add_entry("mix_ext_rd0", 1'b0, 32'hC000_0000, '0, 4'hF, 32'hC000_0000 ^ ExtPattern, 1'b0,
              SideNone);
    add_entry("mix_ctrl_rd", 1'b0, 32'h4000_0010, '0, 4'hF, NumCores, 1'b0, SideNone);
    add_entry("mix_l2_rd", 1'b0, 32'h8000_0100, '0, 4'hF, 32'h0BAD_CAFE, 1'b0, SideNone);
    add_entry("mix_ext_rd1", 1'b0, 32'h3FFF_FFFC, '0, 4'hF, 32'h3FFF_FFFC ^ ExtPattern, 1'b0,
              SideNone);
    add_entry("mix_ctrl_bad", 1'b0, 32'h4000_FF00, '0, 4'hF, '0, 1'b1, SideNone);
    add_entry("mix_ext_rd2", 1'b0, 32'h4001_0000, '0, 4'hF, 32'h4001_0000 ^ ExtPattern, 1'b0,
              SideNone);
    add_entry("mix_l2_rd0", 1'b0, 32'h8000_0000, '0, 4'hF, 32'hDEAD_AA55, 1'b0, SideNone);
    for (int i = 0; i < NumBp; i++) begin
      bp_addr = 32'h5000_0000 + 4 * i;
      case (i % 3)
        0: add_entry($sformatf("bp_l2_%0d", i), 1'b0, 32'h8000_0004, '0, 4'hF, 32'h9922_3344,
                     1'b0, SideNone);
        1: add_entry($sformatf("bp_ext_%0d", i), 1'b0, bp_addr, '0, 4'hF, bp_addr ^ ExtPattern,
                     1'b0, SideNone);
        default: add_entry($sformatf("bp_ctrl_%0d", i), 1'b0, 32'h4000_0010, '0, 4'hF,
                           NumCores, 1'b0, SideNone);
      endcase
    end
    for (int i = 0; i < n_entries; i++) begin
      exp_q.push_back(i);
      if (is_external(tbl_req[i].addr)) begin
        ext_exp_q.push_back(tbl_req[i]);
      end
    end
  endtask

  task automatic wait_for_responses(input int expected, inout bit timed_out);
    int cycles;
    cycles = 0;
    while (rsp_count < expected && cycles < Timeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (rsp_count < expected) begin
      $display("timeout: only %0d of %0d responses arrived", rsp_count, expected);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_for_idle(inout bit timed_out);
    int cycles;
    cycles = 0;
    while (busy_o && cycles < Timeout) begin
      @(posedge clk_i);
      cycles++;
    end
    if (busy_o) begin
      $display("timeout: busy_o stayed high after all responses were received");
      timed_out = 1'b1;
    end
  endtask

  // the requester sends one request per cycle while it holds a credit.
  always @(posedge clk_i) begin
    if (reset_i) begin
      req_credits = ReqCredits;
      next_idx    = 0;
      req_valid_i <= 1'b0;
    end else begin
      if (req_credit_o) begin
        req_credits++;
      end
      if (next_idx < send_limit && req_credits > 0) begin
        req_valid_i <= 1'b1;
        req_i       <= tbl_req[next_idx];
        req_credits--;
        next_idx++;
      end else begin
        req_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : rsp_monitor
    int idx;
    bit ok;
    if (reset_i) begin
      owed = 0;
      rsp_count    <= 0;
      rsp_credit_i <= 1'b0;
    end else begin
      rsp_credit_i <= 1'b0;
      if (rsp_valid_o) begin
        owed++;
        rsp_count <= rsp_count + 1;
        if (exp_q.size() == 0) begin
          $display("a response arrived with no request outstanding");
          error_count++;
        end else begin
          idx = exp_q.pop_front();
          ok  = 1'b1;
          check_value($sformatf("%s.rdata", tbl_name[idx]), tbl_rdata[idx], rsp_o.rdata, ok);
          check_value($sformatf("%s.err", tbl_name[idx]), tbl_err[idx], rsp_o.err, ok);
          if (tbl_side[idx] == SideEoc) begin
            check_value($sformatf("%s.eoc_valid", tbl_name[idx]), 1'b1, eoc_valid_o, ok);
          end
          if (tbl_side[idx] == SideWake) begin
            check_value($sformatf("%s.pulses", tbl_name[idx]), 1, wake_pulses, ok);
            check_value($sformatf("%s.wake_up", tbl_name[idx]),
                        tbl_req[idx].wdata[NumCores-1:0], wake_value, ok);
          end
          report_test(tbl_name[idx], ok);
        end
      end
      if (!hold_credits && owed > 0) begin
        rsp_credit_i <= 1'b1;
        owed--;
      end
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      wake_pulses <= 0;
      wake_value  <= '0;
    end else if (wake_up_o != '0) begin
      wake_pulses <= wake_pulses + 1;
      wake_value  <= wake_up_o;
    end
  end

  always @(posedge clk_i) begin : ext_target_model
    bit       ok;
    sys_req_t expected_req;
    sys_req_t head;
    data_t    word;
    if (reset_i) begin
      ext_rsp_credits = RspCredits;
      ext_cycle       = 0;
      lcg_state       = 32'h6e76;
      ext_req_credit_i <= 1'b0;
      ext_rsp_valid_i  <= 1'b0;
    end else begin
      ext_req_credit_i <= 1'b0;
      ext_rsp_valid_i  <= 1'b0;
      if (ext_rsp_credit_o) begin
        ext_rsp_credits++;
      end
      if (ext_req_valid_o) begin
        ok = 1'b1;
        if (ext_exp_q.size() == 0) begin
          $display("address %h was sent to the external port by mistake", ext_req_o.addr);
          error_count++;
        end else begin
          expected_req = ext_exp_q.pop_front();
          check_value("ext_req_o", expected_req, ext_req_o, ok);
        end
        lcg_state = lcg_next(lcg_state);
        ext_pend_q.push_back(ext_req_o);
        ext_ready_q.push_back(ext_cycle + 1 + int'(lcg_state[17:16])); // 1 to 4 cycles.
        ext_req_credit_i <= 1'b1;
      end
      if (ext_pend_q.size() > 0 && ext_ready_q[0] <= ext_cycle && ext_rsp_credits > 0) begin
        head = ext_pend_q.pop_front();
        void'(ext_ready_q.pop_front());
        word = ext_mem.exists(head.addr) ? ext_mem[head.addr] : head.addr ^ ExtPattern;
        if (head.we) begin
          for (int b = 0; b < 4; b++) begin
            if (head.strb[b]) begin
              word[8*b +: 8] = head.wdata[8*b +: 8];
            end
          end
          ext_mem[head.addr] = word;
          ext_rsp_i <= '0;
        end else begin
          ext_rsp_i <= '{rdata: word, err: 1'b0};
        end
        ext_rsp_valid_i <= 1'b1;
        ext_rsp_credits--;
      end
      ext_cycle++;
    end
  end

  initial begin
    bit timed_out;
    bit ok;
    int n_rsp;
    int late_credits;
    timed_out = 1'b0;
    build_table();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    ok = 1'b1;
    check_value("reset_values", '0, {rsp_valid_o, ext_req_valid_o, req_credit_o,
                ext_rsp_credit_o, wake_up_o, eoc_valid_o, busy_o}, ok);
    report_test("reset_values", ok);
    send_limit <= NumPhase1;
    wait_for_responses(NumPhase1, timed_out);
    if (!timed_out) begin
      wait_for_idle(timed_out);
    end
    if (!timed_out) begin
      repeat (4) @(posedge clk_i);
      hold_credits <= 1'b1;
      send_limit   <= NumEntries;
      n_rsp        = 0;
      late_credits = 0;
      for (int c = 0; c < 40; c++) begin
        @(posedge clk_i);
        if (rsp_valid_o) begin
          n_rsp++;
        end
        if (c >= 30 && req_credit_o) begin
          late_credits++; // the pipeline is full well before this point.
        end
      end
      hold_credits <= 1'b0;
      ok = 1'b1;
      check_value("backpressure_busy", 1'b1, busy_o, ok);
      if (n_rsp > RspCredits) begin
        $display("%0d responses left the DUT while only %0d credits were held", n_rsp,
                 RspCredits);
        error_count++;
        ok = 1'b0;
      end
      if (late_credits > 0) begin
        $display("request credits kept returning while responses were blocked");
        error_count++;
        ok = 1'b0;
      end
      report_test("backpressure_window", ok);
      wait_for_responses(NumEntries, timed_out);
      if (!timed_out) begin
        wait_for_idle(timed_out);
      end
    end
    $display("summary: %0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             error_count);
    if (!timed_out && tests_failed == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_mempool_system

`default_nettype wire
